// ==== tft_demo_pkg.sv ====
package tft_demo_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths.
	//////////////////////////////////////////////////////////////////////
	localparam int COORD_W    = 16; // Coordinate word.
	localparam int COLOR_W    = 16; // RGB565 word.
	localparam int STEP_W     = 4;  // Scene step register.
	localparam int BOLD_W     = 2;  // Bold offset counter.
	localparam int BYTE_CNT_W = 6;  // Holds 0 to 32.
	localparam int REFRESH_W  = 19; // Refresh counter.
	localparam int ROM_AW     = 8;  // Glyph ROM address.

	// Controller command codes.
	typedef enum logic [3:0] {
		INIT     = 4'd0,
		CLEAR    = 4'd1,
		POINT    = 4'd2,
		VLINE    = 4'd3,
		HLINE    = 4'd4,
		SINE     = 4'd5,
		SET_AREA = 4'd6,
		FILL     = 4'd7,
		END_AREA = 4'd8
	} tft_cmd_e;

	// Four argument words, d1 on top, read per command.
	typedef union packed {
		struct packed {
			logic [COORD_W-1:0] d1;
			logic [COORD_W-1:0] d2;
			logic [COORD_W-1:0] d3;
			logic [COORD_W-1:0] d4;
		} words; // Raw view seen by the issuer.
		struct packed {
			logic [COORD_W-1:0] x;
			logic [COORD_W-1:0] y;
			logic [COLOR_W-1:0] color;
			logic [COORD_W-1:0] pad;
		} point;
		struct packed {
			logic [COORD_W-1:0] x;
			logic [COORD_W-1:0] y1;
			logic [COORD_W-1:0] y2;
			logic [COLOR_W-1:0] color;
		} vline;
		struct packed {
			logic [COORD_W-1:0] x1;
			logic [COORD_W-1:0] x2;
			logic [COORD_W-1:0] y;
			logic [COLOR_W-1:0] color;
		} hline;
		struct packed {
			logic [COORD_W-1:0] x1;
			logic [COORD_W-1:0] y1;
			logic [COORD_W-1:0] x2;
			logic [COORD_W-1:0] y2;
		} area;
		struct packed {
			logic [COORD_W-1:0]   pattern; // Glyph byte, zero extended.
			logic [COLOR_W-1:0]   color;
			logic [2*COORD_W-1:0] pad;
		} fill;
		struct packed {
			logic [COORD_W-1:0] x_ofs;
			logic [COORD_W-1:0] y_ofs;
			logic [COLOR_W-1:0] color;
			logic [COORD_W-1:0] pad;
		} sine;
	} tft_args_u;

	//////////////////////////////////////////////////////////////////////
	// Scene geometry and colors.
	//////////////////////////////////////////////////////////////////////
	localparam logic [COLOR_W-1:0] COLOR_BG     = 16'h0000; // Black.
	localparam logic [COLOR_W-1:0] COLOR_MARK   = 16'hFE00; // Yellow.
	localparam logic [COLOR_W-1:0] COLOR_WAVE_A = 16'hF8B2;
	localparam logic [COLOR_W-1:0] COLOR_WAVE_B = 16'h07E0; // Green.

	localparam logic [COORD_W-1:0] CORNER_LO   = 16'd9;
	localparam logic [COORD_W-1:0] CORNER_X_HI = 16'd469;
	localparam logic [COORD_W-1:0] CORNER_Y_HI = 16'd789;
	localparam logic [COORD_W-1:0] FRAME_LO    = 16'd4;
	localparam logic [COORD_W-1:0] FRAME_X_HI  = 16'd474;
	localparam logic [COORD_W-1:0] FRAME_Y_HI  = 16'd794;
	localparam logic [COORD_W-1:0] WAVE_A_X    = 16'd9;
	localparam logic [COORD_W-1:0] WAVE_B_X    = 16'd239;
	localparam logic [COORD_W-1:0] WAVE_Y      = 16'd9;

	localparam logic [BOLD_W-1:0]  BOLD_PASSES = 2'd3; // Offsets 3, 2, 1.

	localparam logic [COORD_W-1:0]    GLYPH_SIZE        = 16'd16; // Edge in pixels.
	localparam logic [BYTE_CNT_W-1:0] GLYPH_BYTES       = 6'd32;
	localparam int                    GLYPHS_PER_STRING = 4;
	localparam logic [COORD_W-1:0]    STRING_A_X        = 16'd430;
	localparam logic [COORD_W-1:0]    STRING_B_X        = 16'd160;
	localparam logic [COORD_W-1:0]    STRING_Y          = 16'd10;

	// 20 MHz / 60 Hz, rounded up.
	localparam logic [REFRESH_W-1:0] REFRESH_DIV  = 19'd333334;
	localparam logic [REFRESH_W-1:0] REFRESH_MARK = 19'd1000;

	//////////////////////////////////////////////////////////////////////
	// Scene steps.
	//////////////////////////////////////////////////////////////////////
	localparam logic [STEP_W-1:0] ST_INIT  = 4'd0;
	localparam logic [STEP_W-1:0] ST_CLEAR = 4'd1;
	localparam logic [STEP_W-1:0] ST_WAIT  = 4'd2;  // Refresh mark.
	localparam logic [STEP_W-1:0] ST_POINT = 4'd3;
	localparam logic [STEP_W-1:0] ST_VLINE = 4'd4;
	localparam logic [STEP_W-1:0] ST_HLINE = 4'd5;
	localparam logic [STEP_W-1:0] ST_SINE  = 4'd6;
	localparam logic [STEP_W-1:0] ST_LOAD  = 4'd7;  // String start, no command.
	localparam logic [STEP_W-1:0] ST_AREA  = 4'd8;
	localparam logic [STEP_W-1:0] ST_FILL  = 4'd9;
	localparam logic [STEP_W-1:0] ST_END   = 4'd10;
	localparam logic [STEP_W-1:0] ST_IDLE  = 4'd11;

endpackage

// ==== tft_cmd_if.sv ====
`timescale 1ns/1ns

interface tft_cmd_if;

	logic                    req;  // Command valid, held until ack.
	tft_demo_pkg::tft_cmd_e  cmd;  // Controller command code.
	tft_demo_pkg::tft_args_u args; // Four argument words.
	logic                    ack;  // One-cycle accept pulse.

	// Scene side.
	modport sequencer (
		output req,
		output cmd,
		output args,
		input  ack
	);

	// Controller side.
	modport issuer (
		input  req,
		input  cmd,
		input  args,
		output ack
	);

	modport monitor (
		input req,
		input cmd,
		input args,
		input ack
	);

endinterface

// ==== cmd_issuer.sv ====
`timescale 1ns/1ns

module cmd_issuer (
	input  logic                             clk_20MHz,
	input  logic                             rst_n,
	input  logic                             tft_done,    // Controller finished.
	output logic                             tft_en,      // Level, held until done.
	output logic [3:0]                       tft_trigger,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data1,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data2,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data3,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data4,
	tft_cmd_if.issuer                        cmd
);

	logic busy; // Command in flight or just acked.

	assign busy = tft_en || cmd.ack;

	//////////////////////////////////////////////////////////////////////
	// Enable-until-done handshake.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			tft_en      <= 1'b0;
			tft_trigger <= tft_demo_pkg::INIT;
			tft_data1   <= '0;
			tft_data2   <= '0;
			tft_data3   <= '0;
			tft_data4   <= '0;
			cmd.ack     <= 1'b0;
		end else begin
			cmd.ack <= 1'b0; // Pulse only.
			if (tft_en) begin
				if (tft_done) begin
					tft_en  <= 1'b0;
					cmd.ack <= 1'b1; // Release the sequencer.
				end
			end else if (cmd.req && !busy) begin
				tft_en      <= 1'b1; // Same edge as the data.
				tft_trigger <= cmd.cmd;
				tft_data1   <= cmd.args.words.d1;
				tft_data2   <= cmd.args.words.d2;
				tft_data3   <= cmd.args.words.d3;
				tft_data4   <= cmd.args.words.d4;
			end
		end
	end

endmodule

// ==== glyph_cursor.sv ====
`timescale 1ns/1ns

module glyph_cursor (
	input  logic                             clk_20MHz,
	input  logic                             rst_n,
	input  logic                             glyph_start,   // Load string origin.
	input  logic                             glyph_next,    // Byte accepted.
	input  logic                             glyph_advance, // Move down one glyph.
	input  logic                             string_sel,    // 0 = string A.
	output logic [7:0]                       glyph_byte,
	output logic                             glyph_last,
	output logic [tft_demo_pkg::COORD_W-1:0] area_x,
	output logic [tft_demo_pkg::COORD_W-1:0] area_y
);

	logic [7:0]                          rom [0:(1 << tft_demo_pkg::ROM_AW) - 1];
	logic [tft_demo_pkg::ROM_AW-1:0]     rom_addr; // Runs across glyphs.
	logic [tft_demo_pkg::BYTE_CNT_W-1:0] byte_cnt; // Bytes sent of this glyph.

	initial $readmemh("glyph_rom.hex", rom); // 8 glyphs of 16x16.

	assign glyph_byte = rom[rom_addr]; // Asynchronous read.
	assign glyph_last = byte_cnt == tft_demo_pkg::GLYPH_BYTES;

	//////////////////////////////////////////////////////////////////////
	// Address, byte count and position.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			rom_addr <= '0;
			byte_cnt <= '0;
			area_x   <= '0;
			area_y   <= '0;
		end else begin
			if (glyph_next) begin
				rom_addr <= rom_addr + 1'b1;
				byte_cnt <= byte_cnt + 1'b1;
			end
			if (glyph_start) begin
				area_x   <= string_sel ? tft_demo_pkg::STRING_B_X : tft_demo_pkg::STRING_A_X;
				area_y   <= tft_demo_pkg::STRING_Y;
				byte_cnt <= '0;
			end else if (glyph_advance) begin
				area_y   <= area_y + tft_demo_pkg::GLYPH_SIZE; // x stays.
				byte_cnt <= '0; // New glyph starts.
			end
		end
	end

endmodule

// ==== scene_sequencer.sv ====
`timescale 1ns/1ns

module scene_sequencer (
	input  logic                             clk_20MHz,
	input  logic                             rst_n,
	input  logic [7:0]                       glyph_byte,    // Current ROM byte.
	input  logic                             glyph_last,    // Glyph fully sent.
	input  logic [tft_demo_pkg::COORD_W-1:0] area_x,        // Glyph corner.
	input  logic [tft_demo_pkg::COORD_W-1:0] area_y,
	output logic                             glyph_start,   // Load string origin.
	output logic                             glyph_next,    // One byte accepted.
	output logic                             glyph_advance, // Next glyph slot.
	output logic                             string_sel,    // 0 = string A.
	tft_cmd_if.sequencer                     cmd
);

	logic [tft_demo_pkg::STEP_W-1:0]    step;
	logic [1:0]                         idx;         // Point, line or glyph number.
	logic [tft_demo_pkg::BOLD_W-1:0]    bold;        // Counts 3, 2, 1.
	logic [1:0]                         pass_q;      // x+, x-, y+, y-.
	logic                               wave_q;      // 0 = wave A.
	logic                               string_q;    // 0 = string A.
	logic [tft_demo_pkg::REFRESH_W-1:0] refresh_cnt;
	logic                               last_glyph;
	logic                               req_c;
	tft_demo_pkg::tft_cmd_e             cmd_c;
	tft_demo_pkg::tft_args_u            args_c;

	// Free-running 60 Hz frame counter.
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			refresh_cnt <= '0;
		end else if (refresh_cnt == tft_demo_pkg::REFRESH_DIV - 1'b1) begin
			refresh_cnt <= '0; // Wrap.
		end else begin
			refresh_cnt <= refresh_cnt + 1'b1;
		end
	end

	assign last_glyph = int'(idx) == tft_demo_pkg::GLYPHS_PER_STRING - 1;

	//////////////////////////////////////////////////////////////////////
	// Step machine, advanced by ack.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_20MHz or negedge rst_n) begin
		if (!rst_n) begin
			step     <= tft_demo_pkg::ST_INIT;
			idx      <= '0;
			bold     <= tft_demo_pkg::BOLD_PASSES;
			pass_q   <= '0;
			wave_q   <= 1'b0;
			string_q <= 1'b0;
		end else begin
			case (step)
				tft_demo_pkg::ST_INIT:
					if (cmd.ack) step <= tft_demo_pkg::ST_CLEAR;
				tft_demo_pkg::ST_CLEAR:
					if (cmd.ack) step <= tft_demo_pkg::ST_WAIT;
				tft_demo_pkg::ST_WAIT:
					if (refresh_cnt == tft_demo_pkg::REFRESH_MARK) begin
						step <= tft_demo_pkg::ST_POINT;
					end
				tft_demo_pkg::ST_POINT:
					if (cmd.ack) begin
						idx <= idx + 1'b1; // Wraps to 0 after corner 3.
						if (idx == 2'd3) step <= tft_demo_pkg::ST_VLINE;
					end
				tft_demo_pkg::ST_VLINE, tft_demo_pkg::ST_HLINE:
					if (cmd.ack) begin
						idx <= {1'b0, ~idx[0]}; // Two lines each.
						if (idx[0]) step <= step + 1'b1;
					end
				tft_demo_pkg::ST_SINE:
					if (cmd.ack) begin
						if (bold == 2'd1) begin
							bold   <= tft_demo_pkg::BOLD_PASSES;
							pass_q <= pass_q + 1'b1;
							if (pass_q == 2'd3) begin
								wave_q <= 1'b1;
								if (wave_q) step <= tft_demo_pkg::ST_LOAD; // Both waves done.
							end
						end else begin
							bold <= bold - 1'b1;
						end
					end
				tft_demo_pkg::ST_LOAD:
					step <= tft_demo_pkg::ST_AREA; // Cursor loads origin here.
				tft_demo_pkg::ST_AREA:
					if (cmd.ack) step <= tft_demo_pkg::ST_FILL;
				tft_demo_pkg::ST_FILL:
					if (glyph_last) step <= tft_demo_pkg::ST_END;
				tft_demo_pkg::ST_END:
					if (cmd.ack) begin
						idx <= idx + 1'b1;
						if (!last_glyph) begin
							step <= tft_demo_pkg::ST_AREA;
						end else if (string_q) begin
							step <= tft_demo_pkg::ST_IDLE; // Scene complete.
						end else begin
							string_q <= 1'b1;
							step     <= tft_demo_pkg::ST_LOAD;
						end
					end
				tft_demo_pkg::ST_IDLE:
					step <= tft_demo_pkg::ST_IDLE;
				default:
					step <= tft_demo_pkg::ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Command table.
	//////////////////////////////////////////////////////////////////////
	always_comb begin : cmd_build
		logic [tft_demo_pkg::COORD_W-1:0] wave_x;
		logic [tft_demo_pkg::COORD_W-1:0] bold_ofs;
		wave_x   = wave_q ? tft_demo_pkg::WAVE_B_X : tft_demo_pkg::WAVE_A_X;
		bold_ofs = '0;
		bold_ofs[tft_demo_pkg::BOLD_W-1:0] = bold;
		req_c  = 1'b1;
		cmd_c  = tft_demo_pkg::INIT;
		args_c = '0;
		case (step)
			tft_demo_pkg::ST_INIT:
				cmd_c = tft_demo_pkg::INIT;
			tft_demo_pkg::ST_CLEAR: begin
				cmd_c           = tft_demo_pkg::CLEAR;
				args_c.words.d1 = tft_demo_pkg::COLOR_BG; // Clear color.
			end
			tft_demo_pkg::ST_POINT: begin
				cmd_c              = tft_demo_pkg::POINT;
				args_c.point.x     = idx[0] ? tft_demo_pkg::CORNER_X_HI : tft_demo_pkg::CORNER_LO;
				args_c.point.y     = idx[1] ? tft_demo_pkg::CORNER_Y_HI : tft_demo_pkg::CORNER_LO;
				args_c.point.color = tft_demo_pkg::COLOR_MARK;
			end
			tft_demo_pkg::ST_VLINE: begin
				cmd_c              = tft_demo_pkg::VLINE;
				args_c.vline.x     = idx[0] ? tft_demo_pkg::FRAME_X_HI : tft_demo_pkg::FRAME_LO;
				args_c.vline.y1    = tft_demo_pkg::FRAME_LO;
				args_c.vline.y2    = tft_demo_pkg::FRAME_Y_HI;
				args_c.vline.color = tft_demo_pkg::COLOR_MARK;
			end
			tft_demo_pkg::ST_HLINE: begin
				cmd_c              = tft_demo_pkg::HLINE;
				args_c.hline.x1    = tft_demo_pkg::FRAME_LO;
				args_c.hline.x2    = tft_demo_pkg::FRAME_X_HI;
				args_c.hline.y     = idx[0] ? tft_demo_pkg::FRAME_Y_HI : tft_demo_pkg::FRAME_LO;
				args_c.hline.color = tft_demo_pkg::COLOR_MARK;
			end
			tft_demo_pkg::ST_SINE: begin
				cmd_c             = tft_demo_pkg::SINE;
				args_c.sine.x_ofs = wave_x;
				args_c.sine.y_ofs = tft_demo_pkg::WAVE_Y;
				case (pass_q)
					2'd0:    args_c.sine.x_ofs = wave_x + bold_ofs;
					2'd1:    args_c.sine.x_ofs = wave_x - bold_ofs;
					2'd2:    args_c.sine.y_ofs = tft_demo_pkg::WAVE_Y + bold_ofs;
					default: args_c.sine.y_ofs = tft_demo_pkg::WAVE_Y - bold_ofs;
				endcase
				args_c.sine.color = wave_q ? tft_demo_pkg::COLOR_WAVE_B
				                           : tft_demo_pkg::COLOR_WAVE_A;
			end
			tft_demo_pkg::ST_AREA: begin
				cmd_c          = tft_demo_pkg::SET_AREA;
				args_c.area.x1 = area_x;
				args_c.area.y1 = area_y;
				args_c.area.x2 = area_x + tft_demo_pkg::GLYPH_SIZE - 16'd1;
				args_c.area.y2 = area_y + tft_demo_pkg::GLYPH_SIZE - 16'd1;
			end
			tft_demo_pkg::ST_FILL: begin
				cmd_c              = tft_demo_pkg::FILL;
				args_c.fill.pattern = {8'h00, glyph_byte};
				args_c.fill.color  = string_q ? tft_demo_pkg::COLOR_WAVE_A
				                              : tft_demo_pkg::COLOR_WAVE_B;
				req_c              = !glyph_last; // Stop after the last byte.
			end
			tft_demo_pkg::ST_END:
				cmd_c = tft_demo_pkg::END_AREA;
			default:
				req_c = 1'b0; // Wait, load and idle send nothing.
		endcase
	end

	assign cmd.req  = req_c;
	assign cmd.cmd  = cmd_c;
	assign cmd.args = args_c;

	assign glyph_start   = step == tft_demo_pkg::ST_LOAD;
	assign glyph_advance = (step == tft_demo_pkg::ST_AREA) && cmd.ack;
	assign glyph_next    = (step == tft_demo_pkg::ST_FILL) && cmd.ack;
	assign string_sel    = string_q;

endmodule

// ==== tft_demo_top.sv ====
`timescale 1ns/1ns

module tft_demo_top (
	input  logic                             clk_20MHz,
	input  logic                             rst_n,
	input  logic                             tft_done,    // Strobe from controller.
	output logic                             tft_en,      // Held until done.
	output logic [3:0]                       tft_trigger,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data1,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data2,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data3,
	output logic [tft_demo_pkg::COORD_W-1:0] tft_data4
);

	logic [7:0]                       glyph_byte;
	logic                             glyph_last;
	logic                             glyph_start;
	logic                             glyph_next;
	logic                             glyph_advance;
	logic                             string_sel;
	logic [tft_demo_pkg::COORD_W-1:0] area_x;
	logic [tft_demo_pkg::COORD_W-1:0] area_y;

	tft_cmd_if cmd_bus (); // Sequencer to issuer.

	scene_sequencer u_sequencer (
		.clk_20MHz     (clk_20MHz),
		.rst_n         (rst_n),
		.glyph_byte    (glyph_byte),
		.glyph_last    (glyph_last),
		.area_x        (area_x),
		.area_y        (area_y),
		.glyph_start   (glyph_start),
		.glyph_next    (glyph_next),
		.glyph_advance (glyph_advance),
		.string_sel    (string_sel),
		.cmd           (cmd_bus.sequencer)
	);

	cmd_issuer u_issuer (
		.clk_20MHz   (clk_20MHz),
		.rst_n       (rst_n),
		.tft_done    (tft_done),
		.tft_en      (tft_en),
		.tft_trigger (tft_trigger),
		.tft_data1   (tft_data1),
		.tft_data2   (tft_data2),
		.tft_data3   (tft_data3),
		.tft_data4   (tft_data4),
		.cmd         (cmd_bus.issuer)
	);

	glyph_cursor u_cursor (
		.clk_20MHz     (clk_20MHz),
		.rst_n         (rst_n),
		.glyph_start   (glyph_start),
		.glyph_next    (glyph_next),
		.glyph_advance (glyph_advance),
		.string_sel    (string_sel),
		.glyph_byte    (glyph_byte),
		.glyph_last    (glyph_last),
		.area_x        (area_x),
		.area_y        (area_y)
	);

endmodule

// ==== tft_demo_properties.sv ====
`timescale 1ns/1ns

module tft_demo_properties (
	input logic                             clk_20MHz,
	input logic                             rst_n,
	input logic                             tft_done,
	input logic                             tft_en,
	input logic [3:0]                       tft_trigger,
	input logic [tft_demo_pkg::COORD_W-1:0] tft_data1,
	input logic [tft_demo_pkg::COORD_W-1:0] tft_data2,
	input logic [tft_demo_pkg::COORD_W-1:0] tft_data3,
	input logic [tft_demo_pkg::COORD_W-1:0] tft_data4,
	input logic                             ack          // Issuer to sequencer.
);

	//////////////////////////////////////////////////////////////////////
	// Controller port handshake.
	//////////////////////////////////////////////////////////////////////

	// Command word frozen while the controller works.
	a_hold_stable: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		tft_en && !tft_done |=>
			$stable({tft_trigger, tft_data1, tft_data2, tft_data3, tft_data4}))
		else $error("command word changed while tft_en was held");

	a_en_falls: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		tft_en && tft_done |=> !tft_en) // Release right after done.
		else $error("tft_en did not fall after tft_done");

	a_ack_pulse: assert property (@(posedge clk_20MHz) disable iff (!rst_n)
		ack |=> !ack) // Single-cycle pulse.
		else $error("ack high for two cycles in a row");

endmodule

// ==== tb_tft_demo.sv ====
`timescale 1ns/1ns

module tb_tft_demo;

	logic        clk_20MHz;
	logic        rst_n;
	logic        tft_done;     // Driven by the controller model.
	logic        tft_en;
	logic [3:0]  tft_trigger;
	logic [15:0] tft_data1;
	logic [15:0] tft_data2;
	logic [15:0] tft_data3;
	logic [15:0] tft_data4;

	logic [7:0]  rom_image [0:255]; // Expected fill bytes.
	logic [7:0]  rom_pos;          // Next byte to see.
	logic [31:0] lfsr;
	int          checks;
	int          value_errors;
	int          other_errors;
	bit          aborted;          // Set on a timeout.

	tft_demo_top uut (
		.clk_20MHz   (clk_20MHz),
		.rst_n       (rst_n),
		.tft_done    (tft_done),
		.tft_en      (tft_en),
		.tft_trigger (tft_trigger),
		.tft_data1   (tft_data1),
		.tft_data2   (tft_data2),
		.tft_data3   (tft_data3),
		.tft_data4   (tft_data4)
	);

	bind cmd_issuer tft_demo_properties u_props (
		.clk_20MHz   (clk_20MHz),
		.rst_n       (rst_n),
		.tft_done    (tft_done),
		.tft_en      (tft_en),
		.tft_trigger (tft_trigger),
		.tft_data1   (tft_data1),
		.tft_data2   (tft_data2),
		.tft_data3   (tft_data3),
		.tft_data4   (tft_data4),
		.ack         (cmd.ack)
	);

	always #25 clk_20MHz = ~clk_20MHz; // 20 MHz.

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// Three fresh bits give 1 to 8 cycles.
	task automatic draw_delay(output int cycles);
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[1:0], lfsr[0]};
		end
		cycles = int'(bits) + 1;
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
	                          input logic [15:0] want);
		checks++;
		assert (got === want) else begin
			value_errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Controller model, one command per call.
	//////////////////////////////////////////////////////////////////////
	task automatic expect_cmd(input logic [3:0] trig, input logic [15:0] d1,
	                          input logic [15:0] d2, input logic [15:0] d3,
	                          input logic [15:0] d4, input int limit);
		int waited;
		int hold;
		if (aborted) return;
		waited = 0;
		while (tft_en !== 1'b1) begin
			if (waited == limit) begin
				other_errors++;
				aborted = 1'b1;
				$display("timeout: tft_en not raised within %0d cycles, expected trigger %0d",
				         limit, trig);
				return;
			end
			@(negedge clk_20MHz);
			waited++;
		end
		check_word("tft_trigger", {12'd0, tft_trigger}, {12'd0, trig});
		check_word("tft_data1", tft_data1, d1);
		check_word("tft_data2", tft_data2, d2);
		check_word("tft_data3", tft_data3, d3);
		check_word("tft_data4", tft_data4, d4);
		draw_delay(hold);
		for (int i = 1; i < hold; i++) begin
			@(negedge clk_20MHz);
			check_word("tft_en", {15'd0, tft_en}, 16'd1); // Held while busy.
		end
		@(posedge clk_20MHz);
		tft_done <= 1'b1;
		@(posedge clk_20MHz);
		tft_done <= 1'b0; // One-cycle strobe.
		@(negedge clk_20MHz);
		check_word("tft_en", {15'd0, tft_en}, 16'd0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests.
	//////////////////////////////////////////////////////////////////////
	task automatic apply_reset();
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_20MHz);
			check_word("tft_en", {15'd0, tft_en}, 16'd0);
			check_word("tft_trigger", {12'd0, tft_trigger}, 16'd0); // INIT.
			check_word("tft_data1", tft_data1, 16'd0);
			check_word("tft_data2", tft_data2, 16'd0);
			check_word("tft_data3", tft_data3, 16'd0);
			check_word("tft_data4", tft_data4, 16'd0);
		end
		@(posedge clk_20MHz);
		rst_n <= 1'b1;
		@(negedge clk_20MHz);
	endtask

	task automatic init_and_clear();
		expect_cmd(tft_demo_pkg::INIT, 16'd0, 16'd0, 16'd0, 16'd0, 20);
		expect_cmd(tft_demo_pkg::CLEAR, tft_demo_pkg::COLOR_BG, 16'd0, 16'd0, 16'd0, 20);
	endtask

	task automatic corner_points();
		logic [15:0] x;
		logic [15:0] y;
		for (int i = 0; i < 4; i++) begin
			x = (i % 2 == 1) ? tft_demo_pkg::CORNER_X_HI : tft_demo_pkg::CORNER_LO;
			y = (i >= 2) ? tft_demo_pkg::CORNER_Y_HI : tft_demo_pkg::CORNER_LO;
			// First point waits out the refresh mark.
			expect_cmd(tft_demo_pkg::POINT, x, y, tft_demo_pkg::COLOR_MARK, 16'd0,
			           (i == 0) ? 2000 : 20);
		end
	endtask

	task automatic frame_lines();
		expect_cmd(tft_demo_pkg::VLINE, tft_demo_pkg::FRAME_LO, tft_demo_pkg::FRAME_LO,
		           tft_demo_pkg::FRAME_Y_HI, tft_demo_pkg::COLOR_MARK, 20);
		expect_cmd(tft_demo_pkg::VLINE, tft_demo_pkg::FRAME_X_HI, tft_demo_pkg::FRAME_LO,
		           tft_demo_pkg::FRAME_Y_HI, tft_demo_pkg::COLOR_MARK, 20);
		expect_cmd(tft_demo_pkg::HLINE, tft_demo_pkg::FRAME_LO, tft_demo_pkg::FRAME_X_HI,
		           tft_demo_pkg::FRAME_LO, tft_demo_pkg::COLOR_MARK, 20);
		expect_cmd(tft_demo_pkg::HLINE, tft_demo_pkg::FRAME_LO, tft_demo_pkg::FRAME_X_HI,
		           tft_demo_pkg::FRAME_Y_HI, tft_demo_pkg::COLOR_MARK, 20);
	endtask

	task automatic sine_passes();
		logic [15:0] base;
		logic [15:0] color;
		logic [15:0] ofs;
		logic [15:0] x;
		logic [15:0] y;
		for (int w = 0; w < 2; w++) begin
			base  = (w == 0) ? tft_demo_pkg::WAVE_A_X : tft_demo_pkg::WAVE_B_X;
			color = (w == 0) ? tft_demo_pkg::COLOR_WAVE_A : tft_demo_pkg::COLOR_WAVE_B;
			for (int p = 0; p < 4; p++) begin // x+, x-, y+, y-.
				for (int b = int'(tft_demo_pkg::BOLD_PASSES); b >= 1; b--) begin
					ofs = (p % 2 == 0) ? 16'(b) : -16'(b); // Odd passes step back.
					x   = base;
					y   = tft_demo_pkg::WAVE_Y;
					if (p < 2) begin
						x = base + ofs;
					end else begin
						y = tft_demo_pkg::WAVE_Y + ofs;
					end
					expect_cmd(tft_demo_pkg::SINE, x, y, color, 16'd0, 20);
				end
			end
		end
	endtask

	task automatic glyph_strings();
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] color;
		for (int s = 0; s < 2; s++) begin
			x     = (s == 0) ? tft_demo_pkg::STRING_A_X : tft_demo_pkg::STRING_B_X;
			color = (s == 0) ? tft_demo_pkg::COLOR_WAVE_B : tft_demo_pkg::COLOR_WAVE_A;
			for (int k = 0; k < tft_demo_pkg::GLYPHS_PER_STRING; k++) begin
				y = tft_demo_pkg::STRING_Y + 16'(k) * tft_demo_pkg::GLYPH_SIZE;
				expect_cmd(tft_demo_pkg::SET_AREA, x, y, x + 16'd15, y + 16'd15, 20);
				for (int n = 0; n < int'(tft_demo_pkg::GLYPH_BYTES); n++) begin
					expect_cmd(tft_demo_pkg::FILL, {8'h00, rom_image[rom_pos]}, color,
					           16'd0, 16'd0, 20);
					rom_pos = rom_pos + 8'd1; // ROM order runs across glyphs.
				end
				expect_cmd(tft_demo_pkg::END_AREA, 16'd0, 16'd0, 16'd0, 16'd0, 20);
			end
		end
	endtask

	// Scene done, bus must stay quiet.
	task automatic idle_window();
		if (aborted) return;
		for (int i = 0; i < 2000; i++) begin
			@(negedge clk_20MHz);
			check_word("tft_en", {15'd0, tft_en}, 16'd0);
		end
	endtask

	initial begin
		clk_20MHz    = 1'b0;
		rst_n        = 1'b0;
		tft_done     = 1'b0;
		lfsr         = 32'h8f5a_8907;
		rom_pos      = 8'd0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		aborted      = 1'b0;
		$readmemh("glyph_rom.hex", rom_image);
		apply_reset();
		init_and_clear();
		corner_points();
		frame_lines();
		sine_passes();
		glyph_strings();
		idle_window();
		$display("checks %0d, value errors %0d, other errors %0d",
		         checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== glyph_rom.hex ====
// Eight 16x16 glyphs of 32 bytes each, two lines per glyph.
// Each line holds eight pixel rows of two bytes, left half first.
FF FF FF FF 01 80 01 80 01 80 01 80 01 80 01 80
01 80 01 80 01 80 01 80 01 80 01 80 01 80 01 80
FF FE FF FE C0 00 C0 00 C0 00 C0 00 C0 00 FF F0
FF F0 C0 00 C0 00 C0 00 C0 00 C0 00 FF FE FF FE
3F FC 7F FE E0 07 E0 00 E0 00 70 00 3F F0 1F FC
00 0E 00 07 00 07 00 07 E0 07 F0 0E 7F FC 3F F8
FF FF FF FF 01 80 01 80 01 80 01 80 01 80 01 80
01 80 01 80 01 80 01 80 01 80 01 80 01 80 01 80
FF E0 FF F8 C0 1C C0 0E C0 06 C0 07 C0 03 C0 03
C0 03 C0 03 C0 07 C0 06 C0 0E C0 1C FF F8 FF E0
FF FE FF FE C0 00 C0 00 C0 00 C0 00 C0 00 FF F0
FF F0 C0 00 C0 00 C0 00 C0 00 C0 00 FF FE FF FE
C0 03 E0 07 F0 0F D8 1B CC 33 C6 63 C3 C3 C1 83
C0 03 C0 03 C0 03 C0 03 C0 03 C0 03 C0 03 C0 03
0F F0 3F FC 70 0E E0 07 C0 03 C0 03 C0 03 C0 03
C0 03 C0 03 C0 03 C0 03 E0 07 70 0E 3F FC 0F F0

// ==== list.f ====
tft_demo_pkg.sv
tft_cmd_if.sv
cmd_issuer.sv
glyph_cursor.sv
scene_sequencer.sv
tft_demo_top.sv
tft_demo_properties.sv
tb_tft_demo.sv

// ==== Makefile ====
TOP := tb_tft_demo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
